// ==== source/fir_defines.svh ====
`ifndef FIR_DEFINES_SVH
`define FIR_DEFINES_SVH

// data widths
`define FIR_SAMPLE_W    16    // Q15 input sample
`define FIR_COEFF_W     16    // Q16 coefficient
`define FIR_PROD_W      31    // product bits kept
`define FIR_ACC_W       33    // Q31 accumulator and output

// filter structure
`define FIR_TAPS        8
`define FIR_PARTITIONS  2
`define FIR_STEPS       4     // taps per partition, cycles per sample

// first half of the symmetric response
`define FIR_COEFF_0     16'hddbb
`define FIR_COEFF_1     16'hea8e
`define FIR_COEFF_2     16'h33db
`define FIR_COEFF_3     16'h6808

`endif

// ==== source/fir_pkg.sv ====
`include "fir_defines.svh"

package fir_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // arithmetic types
  ////////////////////////////////////////////////////////////////////////////

  typedef logic signed [`FIR_SAMPLE_W-1:0] sample_t;  // Q15
  typedef logic signed [`FIR_COEFF_W-1:0]  coeff_t;   // Q16
  typedef logic signed [`FIR_PROD_W-1:0]   prod_t;    // Q31, truncated
  typedef logic signed [`FIR_ACC_W-1:0]    acc_t;     // Q31, wraps mod 2^33

  typedef logic [$clog2(`FIR_STEPS)-1:0] step_t;

  ////////////////////////////////////////////////////////////////////////////
  // tap line to partitions
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    step_t                           step;
    logic                            first;   // step 0 and enabled
    logic                            valid;   // global enable
    sample_t [`FIR_PARTITIONS-1:0]   sample;  // one tap per partition
  } tap_step_t;

  // second half mirrors the first
  localparam coeff_t coeff_table [`FIR_TAPS] = '{
    `FIR_COEFF_0,
    `FIR_COEFF_1,
    `FIR_COEFF_2,
    `FIR_COEFF_3,
    `FIR_COEFF_3,
    `FIR_COEFF_2,
    `FIR_COEFF_1,
    `FIR_COEFF_0
  };

endpackage

// ==== source/fir_tap_line.sv ====
`timescale 1ns/1ns
`include "fir_defines.svh"

module fir_tap_line (
  input  logic                clk,
  input  logic                reset,
  input  logic                clk_enable,
  input  fir_pkg::sample_t    filter_in,
  output fir_pkg::tap_step_t  tap_step,
  output logic                last
);

  import fir_pkg::*;

  localparam step_t LAST_STEP = step_t'(`FIR_STEPS - 1);

  step_t   step_q;
  sample_t delay_line [`FIR_TAPS];
  logic    capture;

  ////////////////////////////////////////////////////////////////////////////
  // phase sequencer
  ////////////////////////////////////////////////////////////////////////////

  // starts on the last step so the first enabled cycle takes a sample
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      step_q <= LAST_STEP;
    end else if (clk_enable) begin
      if (step_q == LAST_STEP) begin
        step_q <= '0;
      end else begin
        step_q <= step_q + 1'b1;
      end
    end
  end

  assign capture = clk_enable && (step_q == LAST_STEP);
  assign last    = capture;

  ////////////////////////////////////////////////////////////////////////////
  // sample delay line
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < `FIR_TAPS; i++) begin
        delay_line[i] <= '0;
      end
    end else if (capture) begin
      delay_line[0] <= filter_in;
      for (int i = 1; i < `FIR_TAPS; i++) begin
        delay_line[i] <= delay_line[i-1];
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // per-step tap selection
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    tap_step.step  = step_q;
    tap_step.first = clk_enable && (step_q == '0);
    tap_step.valid = clk_enable;
    for (int p = 0; p < `FIR_PARTITIONS; p++) begin
      tap_step.sample[p] = delay_line[p * `FIR_STEPS + int'(step_q)];  // taps s, s+4
    end
  end

endmodule

// ==== source/fir_mac_partition.sv ====
`timescale 1ns/1ns
`include "fir_defines.svh"

module fir_mac_partition #(
  parameter int PARTITION = 0
) (
  input  logic                clk,
  input  logic                reset,
  input  fir_pkg::tap_step_t  tap_step,
  output fir_pkg::acc_t       partial_sum
);

  import fir_pkg::*;

  localparam int BASE = PARTITION * `FIR_STEPS;  // first coefficient of this half

  coeff_t                                          coeff;
  sample_t                                         sample;
  logic signed [`FIR_SAMPLE_W+`FIR_COEFF_W-1:0]    full_prod;
  prod_t                                           prod;
  acc_t                                            prod_ext;
  acc_t                                            acc_q;

  ////////////////////////////////////////////////////////////////////////////
  // multiply
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    coeff     = coeff_table[BASE + int'(tap_step.step)];
    sample    = tap_step.sample[PARTITION];
    full_prod = sample * coeff;
    prod      = full_prod[`FIR_PROD_W-1:0];  // drop top bit, Q31
    prod_ext  = {{(`FIR_ACC_W - `FIR_PROD_W){prod[`FIR_PROD_W-1]}}, prod};
  end

  ////////////////////////////////////////////////////////////////////////////
  // accumulate
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      acc_q <= '0;
    end else if (tap_step.valid) begin
      if (tap_step.first) begin
        acc_q <= prod_ext;  // restart on step 0
      end else begin
        acc_q <= acc_q + prod_ext;  // wraps mod 2^33
      end
    end
  end

  assign partial_sum = acc_q;

endmodule

// ==== source/fir_output_stage.sv ====
`timescale 1ns/1ns
`include "fir_defines.svh"

module fir_output_stage (
  input  logic                                  clk,
  input  logic                                  reset,
  input  logic                                  clk_enable,
  input  fir_pkg::acc_t [`FIR_PARTITIONS-1:0]   partial_sum,
  input  logic                                  first,
  input  logic                                  last,
  output fir_pkg::acc_t                         filter_out
);

  import fir_pkg::*;

  acc_t sum;
  acc_t final_q;
  acc_t out_q;

  always_comb begin
    sum = '0;
    for (int p = 0; p < `FIR_PARTITIONS; p++) begin
      sum = sum + partial_sum[p];  // 33-bit wrap
    end
  end

  // final sum on step 0, output on the capture step
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      final_q <= '0;
      out_q   <= '0;
    end else if (clk_enable) begin
      if (first) begin
        final_q <= sum;
      end
      if (last) begin
        out_q <= final_q;
      end
    end
  end

  assign filter_out = out_q;

endmodule

// ==== source/partly_serial_fir.sv ====
`timescale 1ns/1ns
`include "fir_defines.svh"

module partly_serial_fir (
  input  logic              clk,
  input  logic              reset,
  input  logic              clk_enable,
  input  fir_pkg::sample_t  filter_in,
  output fir_pkg::acc_t     filter_out
);

  import fir_pkg::*;

  tap_step_t                       tap_step;
  logic                            last;
  acc_t [`FIR_PARTITIONS-1:0]      partial_sum;

  ////////////////////////////////////////////////////////////////////////////
  // sequencer and delay line
  ////////////////////////////////////////////////////////////////////////////

  fir_tap_line u_fir_tap_line (
    .clk        (clk),
    .reset      (reset),
    .clk_enable (clk_enable),
    .filter_in  (filter_in),
    .tap_step   (tap_step),
    .last       (last)
  );

  ////////////////////////////////////////////////////////////////////////////
  // serial MAC partitions
  ////////////////////////////////////////////////////////////////////////////

  for (genvar p = 0; p < `FIR_PARTITIONS; p++) begin : gen_partition
    fir_mac_partition #(
      .PARTITION (p)
    ) u_fir_mac_partition (
      .clk         (clk),
      .reset       (reset),
      .tap_step    (tap_step),
      .partial_sum (partial_sum[p])
    );
  end

  fir_output_stage u_fir_output_stage (
    .clk         (clk),
    .reset       (reset),
    .clk_enable  (clk_enable),
    .partial_sum (partial_sum),
    .first       (tap_step.first),  // already qualified by enable
    .last        (last),
    .filter_out  (filter_out)
  );

endmodule

// ==== verification/fir_tb.sv ====
`timescale 1ns/1ns

module fir_tb;

  localparam int CLK_HALF     = 5;
  localparam int CLK_PERIOD   = 2 * CLK_HALF;
  localparam int RESET_CYCLES = 10;
  localparam int N_IMPULSE    = 12;
  localparam int N_RANDOM     = 200;
  localparam int N_GAPPED     = 150;
  localparam int N_PRE_RESET  = 20;
  localparam int N_POST_RESET = 30;
  localparam int N_FLUSH      = 3;
  localparam int HIST_DEPTH   = 10;  // output lag 2 plus 8 taps

  // 4 cycles per sample, about 6 with enable gaps
  localparam int PLANNED_CYCLES = 2 * RESET_CYCLES
    + 4 * (N_IMPULSE + N_RANDOM + N_PRE_RESET + N_POST_RESET + N_FLUSH + 2)
    + 6 * N_GAPPED;
  localparam int TIMEOUT_NS = PLANNED_CYCLES * CLK_PERIOD * 2 + 1000;

  localparam logic [31:0] LFSR_SEED = 32'hc84f_66f7;
  localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;  // x^32+x^22+x^2+x+1

  localparam logic signed [15:0] COEFFS [8] = '{
    16'shddbb, 16'shea8e, 16'sh33db, 16'sh6808,
    16'sh6808, 16'sh33db, 16'shea8e, 16'shddbb
  };

  logic               clk = 1'b0;
  logic               reset = 1'b1;
  logic               clk_enable = 1'b0;
  logic signed [15:0] filter_in = '0;
  logic        [32:0] filter_out;

  logic               cap_now = 1'b0;  // next rising edge takes a sample
  logic        [32:0] exp_out = '0;
  int                 model_step = 3;
  logic signed [15:0] hist [$];        // newest sample first
  logic        [31:0] lfsr_state = LFSR_SEED;
  int                 value_errors = 0;
  int                 stable_errors = 0;
  int                 reset_errors = 0;

  partly_serial_fir u_partly_serial_fir (
    .clk        (clk),
    .reset      (reset),
    .clk_enable (clk_enable),
    .filter_in  (filter_in),
    .filter_out (filter_out)
  );

  initial begin
    forever #CLK_HALF clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // random source and reference model
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) return (s >> 1) ^ LFSR_TAPS;
    return s >> 1;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  function automatic logic signed [15:0] random_sample();
    logic [31:0] pick;
    logic [31:0] word;
    pick = rand_bits(3);
    word = rand_bits(16);
    if (pick == 32'd0) return 16'sh8000;  // full-scale negative
    return word[15:0];
  endfunction

  // y for the sample taken lag captures ago
  function automatic logic [32:0] fir_reference(input int lag);
    longint acc;
    longint p;
    int     idx;
    acc = 0;
    for (int k = 0; k < 8; k++) begin
      idx = lag + k;
      if (idx < hist.size()) begin
        p = longint'(COEFFS[k]) * longint'(hist[idx]);
        p = p & 64'h7fff_ffff;  // low 31 bits
        if (p >= 64'sh4000_0000) p = p - 64'sh8000_0000;
        acc = acc + p;
      end
    end
    return acc[32:0];  // mod 2^33
  endfunction

  // account for the rising edge that just passed
  task automatic settle_edge();
    if (!reset && clk_enable) begin
      if (model_step == 3) begin
        hist.push_front(filter_in);
        if (hist.size() > HIST_DEPTH) void'(hist.pop_back());
        exp_out = fir_reference(2);
        model_step = 0;
      end else begin
        model_step = model_step + 1;
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////////

  task automatic drive_cycle(input logic en, input logic signed [15:0] x);
    @(negedge clk);
    settle_edge();
    clk_enable = en;
    filter_in  = x;
    cap_now    = en && (model_step == 3);
  endtask

  // runs cycles until x has been driven on a capture cycle
  task automatic stream_sample(input logic signed [15:0] x, input bit gaps);
    logic en;
    do begin
      en = gaps ? (rand_bits(2) != 32'd0) : 1'b1;  // low about 1 in 4
      drive_cycle(en, x);
    end while (!cap_now);
  endtask

  task automatic apply_reset();
    @(negedge clk);
    reset      = 1'b1;
    clk_enable = 1'b0;
    filter_in  = '0;
    cap_now    = 1'b0;
    model_step = 3;
    exp_out    = '0;
    hist.delete();
    repeat (RESET_CYCLES) @(negedge clk);
    reset = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////////

  a_capture_value: assert property (@(posedge clk) disable iff (reset)
      $past(cap_now) |-> filter_out == exp_out)
    else begin
      value_errors++;
      $display("** Error: filter_out expected %h actual %h", exp_out, $sampled(filter_out));
    end

  a_hold_value: assert property (@(posedge clk) disable iff (reset)
      !$past(cap_now) |-> $stable(filter_out))
    else begin
      stable_errors++;
      $display("** Error: filter_out changed off a capture, expected %h actual %h",
               exp_out, $sampled(filter_out));
    end

  a_reset_clear: assert property (@(posedge clk) $fell(reset) |-> filter_out == '0)
    else begin
      reset_errors++;
      $display("** Error: filter_out after reset expected %h actual %h",
               33'h0, $sampled(filter_out));
    end

  initial begin
    #(TIMEOUT_NS);
    $display("watchdog expired after %0d ns, the stream did not finish", TIMEOUT_NS);
    $display("Test failed");
    $finish;
  end

  initial begin
    apply_reset();
    stream_sample(16'sh7fff, 1'b0);  // impulse
    repeat (N_IMPULSE - 1) stream_sample(16'sh0000, 1'b0);
    repeat (N_RANDOM) stream_sample(random_sample(), 1'b0);
    repeat (N_GAPPED) stream_sample(random_sample(), 1'b1);
    repeat (N_PRE_RESET) stream_sample(random_sample(), 1'b0);
    drive_cycle(1'b1, random_sample());  // stop mid period
    drive_cycle(1'b1, random_sample());
    apply_reset();
    repeat (N_POST_RESET) stream_sample(random_sample(), 1'b0);
    repeat (N_FLUSH) stream_sample(16'sh0000, 1'b0);
    repeat (3) drive_cycle(1'b0, 16'sh0000);
    $display("errors: value %0d, stability %0d, reset %0d",
             value_errors, stable_errors, reset_errors);
    if (value_errors + stable_errors + reset_errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== src.f ====
+incdir+source
source/fir_pkg.sv
source/fir_tap_line.sv
source/fir_mac_partition.sv
source/fir_output_stage.sv
source/partly_serial_fir.sv
verification/fir_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = fir_tb
FILELIST  = src.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = Test failed

SOURCES = $(wildcard source/*.sv source/*.svh verification/*.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "simulation FAILED"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
